//--- include/pktchk_defs.svh
////////////////////
// Widths and register map of the packet checker. The descriptor write
// strobes assume an 11-bit length field in bits 18..8.
////////////////////
`ifndef PKTCHK_DEFS_SVH
`define PKTCHK_DEFS_SVH

// Stream and table geometry
`define PKTCHK_DATA_BYTES 4
`define PKTCHK_NUM_DEST   4
`define PKTCHK_DEST_W     2
`define PKTCHK_LEN_W      11
`define PKTCHK_CNT_W      16
`define PKTCHK_STALL_W    16
`define PKTCHK_ADDR_W     8

// AXI4-Lite register map, byte addresses
`define PKTCHK_ADDR_ARMED       8'h00
`define PKTCHK_ADDR_STALL_LIMIT 8'h04
`define PKTCHK_ADDR_PASS        8'h08
`define PKTCHK_ADDR_FAIL        8'h0C
`define PKTCHK_ADDR_DESC_BASE   8'h10
`define PKTCHK_ADDR_UNEXP       8'h20
`define PKTCHK_ADDR_TIMEOUT     8'h24
`define PKTCHK_ADDR_CLEAR       8'h28

`endif

//--- verilog/pktchk_pkg.sv
////////////////////
// Shared types of the packet checker
////////////////////
`include "pktchk_defs.svh"

package pktchk_pkg;

    // One expected packet per destination
    typedef struct packed {
        logic                     armed;
        logic [7:0]               seed;
        logic [`PKTCHK_LEN_W-1:0] length;
    } desc_t;

    // Packet-level FSM
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RECV    = 2'd1,
        VERDICT = 2'd2
    } state_t;

    // Outcome of one packet, also the counter index
    typedef enum logic [1:0] {
        PASS    = 2'd0,
        FAIL    = 2'd1,
        UNEXP   = 2'd2,
        TIMEOUT = 2'd3
    } verdict_t;

endpackage

//--- verilog/pktchk_beat_if.sv
////////////////////
// One accepted beat, no handshake
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

interface pktchk_beat_if;

    // Strobe for one cycle per accepted beat
    logic                             fire;
    logic                             first;
    logic [`PKTCHK_DATA_BYTES*8-1:0]  data;
    logic [`PKTCHK_DATA_BYTES-1:0]    keep;
    logic                             last;

    modport src (
        output fire, first, data, keep, last
    );

    modport dst (
        input fire, first, data, keep, last
    );

endinterface

//--- verilog/pktchk_axil_regs.sv
////////////////////
// AXI4-Lite slave, one outstanding access per channel, OKAY responses only.
// Counters saturate; a CLEAR write beats a verdict in the same cycle.
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_axil_regs (
    input  logic                         axis_packet_in,
    input  logic                         rst_n,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [`PKTCHK_ADDR_W-1:0]    awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [31:0]                  wdata,
    input  logic [3:0]                   wstrb,
    output logic                         bvalid,
    input  logic                         bready,
    output logic [1:0]                   bresp,
    input  logic                         arvalid,
    output logic                         arready,
    input  logic [`PKTCHK_ADDR_W-1:0]    araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [31:0]                  rdata,
    output logic [1:0]                   rresp,
    input  logic                         verdict_valid,
    input  pktchk_pkg::verdict_t         verdict,
    input  logic                         disarm_en,
    input  logic [`PKTCHK_DEST_W-1:0]    disarm_dest,
    output pktchk_pkg::desc_t            desc_table [`PKTCHK_NUM_DEST],
    output logic [`PKTCHK_STALL_W-1:0]   stall_limit
);

    logic                       wr_en;
    logic                       rd_en;
    logic                       clr_en;
    logic [`PKTCHK_CNT_W-1:0]   cnt_q [4];
    logic [31:0]                rd_word;

    ////////////////////
    // Handshakes

    // Ready only while no response is waiting
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign rd_en   = arvalid && !rvalid;
    assign awready = wr_en;
    assign wready  = wr_en;
    assign arready = rd_en;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;
    assign clr_en  = wr_en && (awaddr == `PKTCHK_ADDR_CLEAR);

    always_ff @(posedge axis_packet_in) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    ////////////////////
    // Writable state

    always_ff @(posedge axis_packet_in) begin
        if (!rst_n) begin
            desc_table  <= '{default: '0};
            stall_limit <= '0;
        end else begin
            if (disarm_en) begin
                desc_table[disarm_dest].armed <= 1'b0;
            end
            // A descriptor write arms it, overriding a disarm in the same cycle
            for (int d = 0; d < `PKTCHK_NUM_DEST; d++) begin
                if (wr_en && awaddr == `PKTCHK_ADDR_DESC_BASE + 4 * d) begin
                    desc_table[d].armed <= 1'b1;
                    if (wstrb[0]) desc_table[d].seed <= wdata[7:0];
                    if (wstrb[1]) desc_table[d].length[7:0] <= wdata[15:8];
                    if (wstrb[2]) desc_table[d].length[10:8] <= wdata[18:16];
                end
            end
            if (wr_en && awaddr == `PKTCHK_ADDR_STALL_LIMIT) begin
                if (wstrb[0]) stall_limit[7:0] <= wdata[7:0];
                if (wstrb[1]) stall_limit[15:8] <= wdata[15:8];
            end
        end
    end

    // Result counters, indexed by verdict
    always_ff @(posedge axis_packet_in) begin
        if (!rst_n) begin
            cnt_q <= '{default: '0};
        end else if (clr_en) begin
            cnt_q <= '{default: '0};
        end else if (verdict_valid && cnt_q[verdict] != '1) begin
            cnt_q[verdict] <= cnt_q[verdict] + 1'b1;
        end
    end

    ////////////////////
    // Read path

    always_comb begin
        rd_word = '0;
        case (araddr)
            `PKTCHK_ADDR_STALL_LIMIT: rd_word[`PKTCHK_STALL_W-1:0] = stall_limit;
            `PKTCHK_ADDR_PASS:        rd_word[`PKTCHK_CNT_W-1:0] = cnt_q[pktchk_pkg::PASS];
            `PKTCHK_ADDR_FAIL:        rd_word[`PKTCHK_CNT_W-1:0] = cnt_q[pktchk_pkg::FAIL];
            `PKTCHK_ADDR_UNEXP:       rd_word[`PKTCHK_CNT_W-1:0] = cnt_q[pktchk_pkg::UNEXP];
            `PKTCHK_ADDR_TIMEOUT:     rd_word[`PKTCHK_CNT_W-1:0] = cnt_q[pktchk_pkg::TIMEOUT];
            `PKTCHK_ADDR_ARMED: begin
                for (int d = 0; d < `PKTCHK_NUM_DEST; d++) begin
                    rd_word[d] = desc_table[d].armed;
                end
            end
            default: begin
                // Descriptor window, anything else reads zero
                for (int d = 0; d < `PKTCHK_NUM_DEST; d++) begin
                    if (araddr == `PKTCHK_ADDR_DESC_BASE + 4 * d) begin
                        rd_word[7:0] = desc_table[d].seed;
                        rd_word[8 +: `PKTCHK_LEN_W] = desc_table[d].length;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge axis_packet_in) begin
        if (rd_en) begin
            rdata <= rd_word;
        end
    end

endmodule

//--- verilog/pktchk_ctrl_fsm.sv
////////////////////
// One packet at a time; s_tready drops for the verdict cycle only
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_ctrl_fsm (
    input  logic                              axis_packet_in,
    input  logic                              rst_n,
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic [`PKTCHK_DATA_BYTES*8-1:0]   s_tdata,
    input  logic [`PKTCHK_DATA_BYTES-1:0]     s_tkeep,
    input  logic                              s_tlast,
    input  logic [`PKTCHK_DEST_W-1:0]         s_tdest,
    input  pktchk_pkg::desc_t                 desc_table [`PKTCHK_NUM_DEST],
    input  logic                              match_ok,
    input  logic [`PKTCHK_LEN_W-1:0]          rx_len,
    input  logic                              expired,
    pktchk_beat_if.src                        beat,
    output logic                              timer_run,
    output logic                              timer_clear,
    output logic                              verdict_valid,
    output pktchk_pkg::verdict_t              verdict,
    output logic                              disarm_en,
    output logic [`PKTCHK_DEST_W-1:0]         disarm_dest
);

    pktchk_pkg::state_t         state;
    pktchk_pkg::state_t         state_nxt;
    logic [`PKTCHK_DEST_W-1:0]  dest_q;
    logic                       armed_q;
    logic                       timeout_q;
    logic                       fire;

    assign s_tready = (state != pktchk_pkg::VERDICT);
    assign fire     = s_tvalid && s_tready;

    // Beat to the comparator
    assign beat.fire  = fire;
    assign beat.first = (state == pktchk_pkg::IDLE);
    assign beat.data  = s_tdata;
    assign beat.keep  = s_tkeep;
    assign beat.last  = s_tlast;

    // Gap timer runs only inside a packet with no beat
    assign timer_run   = (state == pktchk_pkg::RECV) && !fire;
    assign timer_clear = !timer_run;

    // Current destination; also selects the seed for the first beat
    assign disarm_dest = (state == pktchk_pkg::IDLE) ? s_tdest : dest_q;

    always_comb begin
        state_nxt = state;
        case (state)
            pktchk_pkg::IDLE: begin
                if (fire) begin
                    state_nxt = s_tlast ? pktchk_pkg::VERDICT : pktchk_pkg::RECV;
                end
            end
            pktchk_pkg::RECV: begin
                if ((fire && s_tlast) || expired) begin
                    state_nxt = pktchk_pkg::VERDICT;
                end
            end
            default: state_nxt = pktchk_pkg::IDLE;
        endcase
    end

    always_ff @(posedge axis_packet_in) begin
        if (!rst_n) begin
            state     <= pktchk_pkg::IDLE;
            dest_q    <= '0;
            armed_q   <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == pktchk_pkg::IDLE && fire) begin
                dest_q    <= s_tdest;
                armed_q   <= desc_table[s_tdest].armed;
                timeout_q <= 1'b0;
            end else if (state == pktchk_pkg::RECV && expired) begin
                timeout_q <= 1'b1;
            end
        end
    end

    ////////////////////
    // Verdict

    assign verdict_valid = (state == pktchk_pkg::VERDICT);
    assign disarm_en     = verdict_valid && armed_q;

    always_comb begin
        if (!armed_q) begin
            verdict = pktchk_pkg::UNEXP;
        end else if (timeout_q) begin
            verdict = pktchk_pkg::TIMEOUT;
        end else if (match_ok && rx_len == desc_table[dest_q].length) begin
            verdict = pktchk_pkg::PASS;
        end else begin
            verdict = pktchk_pkg::FAIL;
        end
    end

endmodule

//--- verilog/pktchk_stall_timer.sv
////////////////////
// A limit of zero never expires
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_stall_timer (
    input  logic                        axis_packet_in,
    input  logic                        rst_n,
    input  logic                        timer_run,
    input  logic                        timer_clear,
    input  logic [`PKTCHK_STALL_W-1:0]  stall_limit,
    output logic                        expired
);

    logic [`PKTCHK_STALL_W-1:0] idle_cnt;

    // Fires in the idle cycle that brings the count up to the limit
    assign expired = timer_run && (stall_limit != '0) && (idle_cnt == stall_limit - 1'b1);

    always_ff @(posedge axis_packet_in) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (timer_clear) begin
            idle_cnt <= '0;
        end else if (timer_run && idle_cnt != '1) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/pktchk_byte_compare.sv
////////////////////
// Kept bytes are the low lanes; a partial beat before tlast counts as a mismatch
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_byte_compare (
    input  logic                        axis_packet_in,
    input  logic                        rst_n,
    pktchk_beat_if.dst                  beat,
    input  logic [7:0]                  seed,
    output logic                        match_ok,
    output logic [`PKTCHK_LEN_W-1:0]    rx_len
);

    logic                       bad_q;
    logic [`PKTCHK_LEN_W-1:0]   len_q;
    logic                       base_bad;
    logic [`PKTCHK_LEN_W-1:0]   base_len;
    logic [`PKTCHK_LEN_W-1:0]   kept_cnt;
    logic                       beat_bad;
    logic [7:0]                 exp_byte;

    // First beat restarts the accumulation
    assign base_bad = (beat.fire && beat.first) ? 1'b0 : bad_q;
    assign base_len = (beat.fire && beat.first) ? '0 : len_q;

    ////////////////////
    // Pattern compare

    always_comb begin
        kept_cnt = '0;
        beat_bad = 1'b0;
        exp_byte = '0;
        for (int i = 0; i < `PKTCHK_DATA_BYTES; i++) begin
            // Byte k of the packet is seed + k
            exp_byte = seed + base_len[7:0] + 8'(i);
            if (beat.keep[i]) begin
                kept_cnt = kept_cnt + 1'b1;
                if (beat.data[8*i +: 8] != exp_byte) begin
                    beat_bad = 1'b1;
                end
            end
        end
        if (!beat.last && beat.keep != '1) begin
            beat_bad = 1'b1;
        end
    end

    // Both outputs include the beat being accepted now
    assign match_ok = !(base_bad || (beat.fire && beat_bad));
    assign rx_len   = base_len + (beat.fire ? kept_cnt : '0);

    always_ff @(posedge axis_packet_in) begin
        if (!rst_n) begin
            bad_q <= 1'b0;
            len_q <= '0;
        end else if (beat.fire) begin
            bad_q <= !match_ok;
            len_q <= rx_len;
        end
    end

endmodule

//--- verilog/pktchk_top.sv
////////////////////
// No interleaving across tdest; tid, tuser and tstrb are not present
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_top (
    input  logic                              axis_packet_in,
    input  logic                              rst_n,
    // AXI4-Stream sink
    input  logic                              s_tvalid,
    output logic                              s_tready,
    input  logic [`PKTCHK_DATA_BYTES*8-1:0]   s_tdata,
    input  logic [`PKTCHK_DATA_BYTES-1:0]     s_tkeep,
    input  logic                              s_tlast,
    input  logic [`PKTCHK_DEST_W-1:0]         s_tdest,
    // AXI4-Lite control
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [`PKTCHK_ADDR_W-1:0]         awaddr,
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [31:0]                       wdata,
    input  logic [3:0]                        wstrb,
    output logic                              bvalid,
    input  logic                              bready,
    output logic [1:0]                        bresp,
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [`PKTCHK_ADDR_W-1:0]         araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output logic [31:0]                       rdata,
    output logic [1:0]                        rresp
);

    pktchk_pkg::desc_t          desc_table [`PKTCHK_NUM_DEST];
    logic [`PKTCHK_STALL_W-1:0] stall_limit;
    logic                       verdict_valid;
    pktchk_pkg::verdict_t       verdict;
    logic                       disarm_en;
    logic [`PKTCHK_DEST_W-1:0]  disarm_dest;
    logic                       timer_run;
    logic                       timer_clear;
    logic                       expired;
    logic                       match_ok;
    logic [`PKTCHK_LEN_W-1:0]   rx_len;
    logic [7:0]                 seed;

    pktchk_beat_if u_beat ();

    // Seed of the packet in progress
    assign seed = desc_table[disarm_dest].seed;

    pktchk_axil_regs u_regs (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict),
        .disarm_en      (disarm_en),
        .disarm_dest    (disarm_dest),
        .desc_table     (desc_table),
        .stall_limit    (stall_limit)
    );

    pktchk_ctrl_fsm u_fsm (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .s_tvalid       (s_tvalid),
        .s_tready       (s_tready),
        .s_tdata        (s_tdata),
        .s_tkeep        (s_tkeep),
        .s_tlast        (s_tlast),
        .s_tdest        (s_tdest),
        .desc_table     (desc_table),
        .match_ok       (match_ok),
        .rx_len         (rx_len),
        .expired        (expired),
        .beat           (u_beat),
        .timer_run      (timer_run),
        .timer_clear    (timer_clear),
        .verdict_valid  (verdict_valid),
        .verdict        (verdict),
        .disarm_en      (disarm_en),
        .disarm_dest    (disarm_dest)
    );

    pktchk_stall_timer u_timer (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .timer_run      (timer_run),
        .timer_clear    (timer_clear),
        .stall_limit    (stall_limit),
        .expired        (expired)
    );

    pktchk_byte_compare u_cmp (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .beat           (u_beat),
        .seed           (seed),
        .match_ok       (match_ok),
        .rx_len         (rx_len)
    );

endmodule

//--- verif/pktchk_chk.sv
////////////////////
// Stream and AXI4-Lite protocol rules, bound into pktchk_top
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_chk (
    input logic                              axis_packet_in,
    input logic                              rst_n,
    input logic                              s_tvalid,
    input logic                              s_tready,
    input logic [`PKTCHK_DATA_BYTES*8-1:0]   s_tdata,
    input logic                              s_tlast,
    input logic                              bvalid,
    input logic                              bready,
    input logic                              rvalid,
    input logic                              rready
);

    // Number of failed assertions
    int unsigned fail_cnt = 0;

    // A stalled beat must not change
    stream_hold: assert property (@(posedge axis_packet_in) disable iff (!rst_n)
        (s_tvalid && !s_tready) |=> ($stable(s_tdata) && $stable(s_tlast)))
    else begin
        fail_cnt++;
        $error("stream beat changed while stalled");
    end

    b_hold: assert property (@(posedge axis_packet_in) disable iff (!rst_n)
        (bvalid && !bready) |=> bvalid)
    else begin
        fail_cnt++;
        $error("bvalid dropped before bready");
    end

    r_hold: assert property (@(posedge axis_packet_in) disable iff (!rst_n)
        (rvalid && !rready) |=> rvalid)
    else begin
        fail_cnt++;
        $error("rvalid dropped before rready");
    end

    // One back-pressure cycle per packet end
    verdict_gap: assert property (@(posedge axis_packet_in) disable iff (!rst_n)
        (s_tvalid && s_tready && s_tlast) |=> !s_tready ##1 s_tready)
    else begin
        fail_cnt++;
        $error("s_tready not low for exactly one cycle after tlast");
    end

endmodule

bind pktchk_top pktchk_chk u_chk (
    .axis_packet_in (axis_packet_in),
    .rst_n          (rst_n),
    .s_tvalid       (s_tvalid),
    .s_tready       (s_tready),
    .s_tdata        (s_tdata),
    .s_tlast        (s_tlast),
    .bvalid         (bvalid),
    .bready         (bready),
    .rvalid         (rvalid),
    .rready         (rready)
);

//--- verif/pktchk_tb.sv
////////////////////
// Random packets from a fixed LFSR seed; needs STALL_LIMIT 8 with gaps of at most 3
////////////////////
`timescale 1ns/1ps
`include "pktchk_defs.svh"

module pktchk_tb;

    localparam int NUM_PKTS    = 60 + 8;
    localparam int STALL_GAP   = 12 + 10 * 3;
    localparam int AXI_CYCLES  = 8 * 6;
    localparam int CYCLE_LIMIT = 2 * (NUM_PKTS * (2 + 64 + STALL_GAP + AXI_CYCLES) + 200);

    logic                             axis_packet_in;
    logic                             rst_n;
    logic                             s_tvalid;
    logic                             s_tready;
    logic [`PKTCHK_DATA_BYTES*8-1:0]  s_tdata;
    logic [`PKTCHK_DATA_BYTES-1:0]    s_tkeep;
    logic                             s_tlast;
    logic [`PKTCHK_DEST_W-1:0]        s_tdest;
    logic                             awvalid;
    logic                             awready;
    logic [`PKTCHK_ADDR_W-1:0]        awaddr;
    logic                             wvalid;
    logic                             wready;
    logic [31:0]                      wdata;
    logic [3:0]                       wstrb;
    logic                             bvalid;
    logic                             bready;
    logic [1:0]                       bresp;
    logic                             arvalid;
    logic                             arready;
    logic [`PKTCHK_ADDR_W-1:0]        araddr;
    logic                             rvalid;
    logic                             rready;
    logic [31:0]                      rdata;
    logic [1:0]                       rresp;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] lfsr_q = 32'd84;
    logic [7:0]  pkt_q [$];

    // Reference model
    logic        m_armed [`PKTCHK_NUM_DEST];
    int          m_pass  = 0;
    int          m_fail  = 0;
    int          m_unexp = 0;
    int          m_tmo   = 0;

    pktchk_top u_dut (.*);

    initial begin
        axis_packet_in = 1'b0;
        forever #5 axis_packet_in = ~axis_packet_in;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge axis_packet_in);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing the tests", cycles);
        $display("Regression failed");
        $finish;
    end

    ////////////////////
    // Helpers

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | lfsr_q[0];
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED: %s expected 0x%08h got 0x%08h", name, exp, got);
        end
    endtask

    // Ready for the response comes a cycle late so bvalid has to hold
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge axis_packet_in);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        @(negedge axis_packet_in);
        while (!(awready && wready)) @(negedge axis_packet_in);
        @(posedge axis_packet_in);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge axis_packet_in);
        while (!bvalid) @(negedge axis_packet_in);
        check_eq("bresp", 32'h0, 32'(bresp));
        @(posedge axis_packet_in);
        bready <= 1'b1;
        @(posedge axis_packet_in);
        bready <= 1'b0;
    endtask

    // Same late ready on the read data channel
    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge axis_packet_in);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(negedge axis_packet_in);
        while (!arready) @(negedge axis_packet_in);
        @(posedge axis_packet_in);
        arvalid <= 1'b0;
        @(negedge axis_packet_in);
        while (!rvalid) @(negedge axis_packet_in);
        data = rdata;
        check_eq("rresp", 32'h0, 32'(rresp));
        @(posedge axis_packet_in);
        rready <= 1'b1;
        @(posedge axis_packet_in);
        rready <= 1'b0;
    endtask

    // Counters and ARMED against the model
    task automatic check_state();
        logic [31:0] got;
        logic [31:0] exp_armed;
        exp_armed = '0;
        for (int d = 0; d < `PKTCHK_NUM_DEST; d++) begin
            exp_armed[d] = m_armed[d];
        end
        axil_read(`PKTCHK_ADDR_ARMED, got);
        check_eq("ARMED", exp_armed, got);
        axil_read(`PKTCHK_ADDR_PASS, got);
        check_eq("PASS", 32'(m_pass), got);
        axil_read(`PKTCHK_ADDR_FAIL, got);
        check_eq("FAIL", 32'(m_fail), got);
        axil_read(`PKTCHK_ADDR_UNEXP, got);
        check_eq("UNEXP", 32'(m_unexp), got);
        axil_read(`PKTCHK_ADDR_TIMEOUT, got);
        check_eq("TIMEOUT", 32'(m_tmo), got);
    endtask

    ////////////////////
    // Stream side

    // Sends pkt_q; stall_len idle cycles go before beat stall_beat
    task automatic send_packet(input int dest, input int stall_beat, input int stall_len);
        int          n;
        int          nbeats;
        int          gap;
        int          rem;
        logic [31:0] data;
        logic [3:0]  keep;
        n = pkt_q.size();
        nbeats = (n + 3) / 4;
        for (int b = 0; b < nbeats; b++) begin
            gap = 0;
            if (b == stall_beat) begin
                gap = stall_len;
            end else if (b > 0) begin
                gap = rand_bits(2);
            end
            repeat (gap) begin
                @(posedge axis_packet_in);
                s_tvalid <= 1'b0;
            end
            rem = n - 4 * b;
            data = '0;
            keep = '0;
            for (int i = 0; i < `PKTCHK_DATA_BYTES && i < rem; i++) begin
                data[8*i +: 8] = pkt_q[4*b + i];
                keep[i] = 1'b1;
            end
            @(posedge axis_packet_in);
            s_tvalid <= 1'b1;
            s_tdata  <= data;
            s_tkeep  <= keep;
            s_tlast  <= (b == nbeats - 1);
            s_tdest  <= dest[1:0];
            @(negedge axis_packet_in);
            while (!s_tready) @(negedge axis_packet_in);
        end
        @(posedge axis_packet_in);
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
    endtask

    // Verdict cycle shows as s_tready low and counters move on the next edge
    task automatic wait_verdict();
        @(negedge axis_packet_in);
        while (s_tready) @(negedge axis_packet_in);
        @(posedge axis_packet_in);
    endtask

    // 0 pass, 1 flipped byte, 2 long, 3 short, 4 unarmed, 5 stall timeout, 6 short gap,
    // 7 stall of exactly the limit
    task automatic run_case(input int kind);
        int         dest;
        int         len;
        int         n;
        int         flip;
        int         stall_beat;
        int         stall_len;
        logic [7:0] sd;
        dest = rand_bits(2);
        sd = 8'(rand_bits(8));
        len = 1 + rand_bits(6) % 40;
        stall_beat = -1;
        stall_len = 0;
        if (kind == 4) begin
            // Needs an unarmed destination or falls back to a passing packet
            kind = 0;
            for (int i = 0; i < `PKTCHK_NUM_DEST; i++) begin
                if (kind == 0 && !m_armed[(dest + i) % `PKTCHK_NUM_DEST]) begin
                    dest = (dest + i) % `PKTCHK_NUM_DEST;
                    kind = 4;
                end
            end
        end
        if (kind == 3 && len < 2) begin
            len = 2;
        end
        if (kind >= 5 && len < 8) begin
            len = len + 8;
        end
        n = len;
        if (kind == 2) n = len + 1;
        if (kind == 3) n = len - 1;
        if (kind != 4) begin
            axil_write(8'(`PKTCHK_ADDR_DESC_BASE + 4 * dest), (32'(len) << 8) | 32'(sd));
            m_armed[dest] = 1'b1;
        end
        pkt_q.delete();
        for (int k = 0; k < n; k++) begin
            pkt_q.push_back(8'(sd + k));
        end
        if (kind == 1) begin
            flip = rand_bits(6) % len;
            pkt_q[flip] = pkt_q[flip] ^ 8'(1 + rand_bits(8) % 255);
        end
        if (kind >= 5) begin
            stall_beat = 1 + rand_bits(4) % ((n + 3) / 4 - 1);
            if (kind == 5) begin
                stall_len = 12;
            end else if (kind == 6) begin
                stall_len = 4;
            end else begin
                // The resumed beat meets the verdict cycle and is held back
                stall_len = 8;
            end
        end
        send_packet(dest, stall_beat, stall_len);
        wait_verdict();
        case (kind)
            0, 6: m_pass++;
            1, 2, 3: m_fail++;
            4: m_unexp++;
            // Beats after the abort arrive as a packet on a now unarmed destination
            default: begin
                m_tmo++;
                m_unexp++;
            end
        endcase
        if (kind != 4) begin
            m_armed[dest] = 1'b0;
        end
        check_state();
    endtask

    ////////////////////
    // Test sequence

    initial begin
        logic [31:0] got;
        rst_n    = 1'b0;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tlast  = 1'b0;
        s_tdest  = '0;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        for (int d = 0; d < `PKTCHK_NUM_DEST; d++) begin
            m_armed[d] = 1'b0;
        end
        repeat (5) @(posedge axis_packet_in);
        rst_n <= 1'b1;
        check_state();

        // Register readback and unmapped space
        axil_read(`PKTCHK_ADDR_STALL_LIMIT, got);
        check_eq("STALL_LIMIT", 32'h0, got);
        axil_write(`PKTCHK_ADDR_STALL_LIMIT, 32'h0000_1234);
        axil_read(`PKTCHK_ADDR_STALL_LIMIT, got);
        check_eq("STALL_LIMIT", 32'h0000_1234, got);
        axil_write(8'(`PKTCHK_ADDR_DESC_BASE + 8), 32'h0003_FFA5);
        m_armed[2] = 1'b1;
        axil_read(8'(`PKTCHK_ADDR_DESC_BASE + 8), got);
        check_eq("DESC2", 32'h0003_FFA5, got);
        axil_read(8'h2C, got);
        check_eq("rdata at 0x2C", 32'h0, got);
        axil_read(8'h30, got);
        check_eq("rdata at 0x30", 32'h0, got);
        axil_read(8'hFC, got);
        check_eq("rdata at 0xFC", 32'h0, got);
        axil_write(`PKTCHK_ADDR_STALL_LIMIT, 32'd8);
        axil_read(`PKTCHK_ADDR_STALL_LIMIT, got);
        check_eq("STALL_LIMIT", 32'd8, got);
        check_state();

        // Each behavior once and then the random mix
        for (int k = 0; k < 8; k++) begin
            run_case(k);
        end
        repeat (60) begin
            run_case(rand_bits(3));
        end

        axil_write(`PKTCHK_ADDR_CLEAR, 32'h0);
        m_pass = 0;
        m_fail = 0;
        m_unexp = 0;
        m_tmo = 0;
        check_state();

        if (u_dut.u_chk.fail_cnt != 0) begin
            $display("Protocol assertions failed %0d times", u_dut.u_chk.fail_cnt);
            errors += u_dut.u_chk.fail_cnt;
        end
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/pktchk_pkg.sv
verilog/pktchk_beat_if.sv
verilog/pktchk_axil_regs.sv
verilog/pktchk_ctrl_fsm.sv
verilog/pktchk_stall_timer.sv
verilog/pktchk_byte_compare.sv
verilog/pktchk_top.sv
verif/pktchk_chk.sv
verif/pktchk_tb.sv

//--- Makefile
# Verilator simulation of the packet checker testbench

TOP := pktchk_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -Mdir obj_dir -o $(TOP)

# The run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
